//--- design/sad_pkg.sv
`default_nettype none

package sad_pkg;

    // threshold port is one full word
    localparam int THRESHOLD_BITS = 32;

    // differences added per first-stage adder
    localparam int SUM_GROUP = 4;

    // run state machine encodings
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RUNNING = 2'd1;
    localparam logic [1:0] ST_DONE    = 2'd2;

    // bits needed to hold count values of width bits added together
    function automatic int sum_bits(input int count, input int width);
        return width + $clog2(count);
    endfunction

    // bits needed to address count entries, never less than one
    function automatic int index_bits(input int count);
        if (count > 1) begin
            return $clog2(count);
        end
        return 1;
    endfunction

endpackage

`default_nettype wire

//--- design/sad_reference_store.sv
`default_nettype none

module sad_reference_store
    import sad_pkg::*;
#(
    parameter int REF_SAMPLES = 32,
    parameter int SAMPLE_BITS = 8
) (
    input  wire                                     adc_sampleclk,
    input  wire                                     reset,
    input  wire                                     ref_wr,
    input  wire  [index_bits(REF_SAMPLES)-1:0]      ref_index,
    input  wire  [SAMPLE_BITS-1:0]                  ref_data,
    output logic [REF_SAMPLES*SAMPLE_BITS-1:0]      ref_samples
);

    logic [SAMPLE_BITS-1:0] ref_mem [REF_SAMPLES];

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            for (int i = 0; i < REF_SAMPLES; i++) begin
                ref_mem[i] <= '0;
            end
        end else if (ref_wr && (ref_index < REF_SAMPLES)) begin  // ignore slots past the end
            ref_mem[ref_index] <= ref_data;
        end
    end

    // flatten, slot 0 in the low bits
    genvar g;
    generate
        for (g = 0; g < REF_SAMPLES; g++) begin : gen_flat
            assign ref_samples[g*SAMPLE_BITS +: SAMPLE_BITS] = ref_mem[g];
        end
    endgenerate

endmodule

`default_nettype wire

//--- design/sad_sample_window.sv
`default_nettype none

module sad_sample_window
    import sad_pkg::*;
#(
    parameter int REF_SAMPLES = 32,
    parameter int SAMPLE_BITS = 8
) (
    input  wire                                     adc_sampleclk,
    input  wire                                     reset,
    input  wire                                     capture_en,
    input  wire  [SAMPLE_BITS-1:0]                  adc_datain,
    output logic [REF_SAMPLES*SAMPLE_BITS-1:0]      window_samples,
    output logic                                    window_valid
);

    localparam int FILL_BITS = index_bits(REF_SAMPLES + 1);

    logic [SAMPLE_BITS-1:0] win [REF_SAMPLES];
    logic [FILL_BITS-1:0]   fill_cnt;

    // shift towards slot 0, newest sample lands in the top slot
    always_ff @(posedge adc_sampleclk) begin
        if (capture_en) begin
            for (int i = 0; i < REF_SAMPLES - 1; i++) begin
                win[i] <= win[i+1];
            end
            win[REF_SAMPLES-1] <= adc_datain;
        end
    end

    // counts samples since capture started, saturates at a full window
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !capture_en) begin
            fill_cnt     <= '0;
            window_valid <= 1'b0;
        end else begin
            if (fill_cnt < FILL_BITS'(REF_SAMPLES)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            // this edge completes or extends a full window
            window_valid <= (fill_cnt >= FILL_BITS'(REF_SAMPLES - 1));
        end
    end

    genvar g;
    generate
        for (g = 0; g < REF_SAMPLES; g++) begin : gen_flat
            assign window_samples[g*SAMPLE_BITS +: SAMPLE_BITS] = win[g];
        end
    endgenerate

endmodule

`default_nettype wire

//--- design/sad_abs_diff.sv
`default_nettype none

module sad_abs_diff #(
    parameter int REF_SAMPLES = 32,
    parameter int SAMPLE_BITS = 8
) (
    input  wire                                     adc_sampleclk,
    input  wire                                     reset,
    input  wire  [REF_SAMPLES*SAMPLE_BITS-1:0]      window_samples,
    input  wire                                     window_valid,
    input  wire  [REF_SAMPLES*SAMPLE_BITS-1:0]      ref_samples,
    output logic [REF_SAMPLES*SAMPLE_BITS-1:0]      diffs,
    output logic                                    diff_valid
);

    logic [SAMPLE_BITS-1:0] smp [REF_SAMPLES];
    logic [SAMPLE_BITS-1:0] ref_smp [REF_SAMPLES];

    genvar g;
    generate
        for (g = 0; g < REF_SAMPLES; g++) begin : gen_slot
            assign smp[g]     = window_samples[g*SAMPLE_BITS +: SAMPLE_BITS];
            assign ref_smp[g] = ref_samples[g*SAMPLE_BITS +: SAMPLE_BITS];

            // larger minus smaller keeps it unsigned
            always_ff @(posedge adc_sampleclk) begin
                if (smp[g] > ref_smp[g]) begin
                    diffs[g*SAMPLE_BITS +: SAMPLE_BITS] <= smp[g] - ref_smp[g];
                end else begin
                    diffs[g*SAMPLE_BITS +: SAMPLE_BITS] <= ref_smp[g] - smp[g];
                end
            end
        end
    endgenerate

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            diff_valid <= 1'b0;
        end else begin
            diff_valid <= window_valid;  // follows its window by one stage
        end
    end

endmodule

`default_nettype wire

//--- design/sad_sum_tree.sv
`default_nettype none

module sad_sum_tree
    import sad_pkg::*;
#(
    parameter int REF_SAMPLES = 32,
    parameter int SAMPLE_BITS = 8
) (
    input  wire                                             adc_sampleclk,
    input  wire                                             reset,
    input  wire  [REF_SAMPLES*SAMPLE_BITS-1:0]              diffs,
    input  wire                                             diff_valid,
    output logic [sum_bits(REF_SAMPLES, SAMPLE_BITS)-1:0]   sad_value,
    output logic                                            sad_valid
);

    localparam int GROUPS    = REF_SAMPLES / SUM_GROUP;
    localparam int PART_BITS = sum_bits(SUM_GROUP, SAMPLE_BITS);
    localparam int SAD_BITS  = sum_bits(REF_SAMPLES, SAMPLE_BITS);

    generate
        if (REF_SAMPLES % SUM_GROUP != 0) begin : gen_bad_size
            $error("REF_SAMPLES must be a multiple of SUM_GROUP");
        end
    endgenerate

    logic [PART_BITS-1:0] part_next [GROUPS];
    logic [PART_BITS-1:0] part_q    [GROUPS];
    logic [SAD_BITS-1:0]  total_next;
    logic                 part_valid;

    // stage one, SUM_GROUP differences per adder
    always_comb begin
        for (int grp = 0; grp < GROUPS; grp++) begin
            part_next[grp] = '0;
            for (int k = 0; k < SUM_GROUP; k++) begin
                part_next[grp] = part_next[grp]
                    + PART_BITS'(diffs[(grp*SUM_GROUP + k)*SAMPLE_BITS +: SAMPLE_BITS]);
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        for (int grp = 0; grp < GROUPS; grp++) begin
            part_q[grp] <= part_next[grp];
        end
    end

    // stage two, total of the partials
    always_comb begin
        total_next = '0;
        for (int grp = 0; grp < GROUPS; grp++) begin
            total_next = total_next + SAD_BITS'(part_q[grp]);
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        sad_value <= total_next;
    end

    // one valid per stage, so two windows can be in flight
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            part_valid <= 1'b0;
            sad_valid  <= 1'b0;
        end else begin
            part_valid <= diff_valid;
            sad_valid  <= part_valid;
        end
    end

endmodule

`default_nettype wire

//--- design/sad_trigger_control.sv
`default_nettype none

module sad_trigger_control
    import sad_pkg::*;
#(
    parameter int REF_SAMPLES = 32,
    parameter int SAMPLE_BITS = 8
) (
    input  wire                                             adc_sampleclk,
    input  wire                                             reset,
    input  wire                                             armed_and_ready,
    input  wire                                             active,
    input  wire  [THRESHOLD_BITS-1:0]                       threshold,
    input  wire                                             multiple_triggers,
    input  wire                                             clear_status,
    input  wire  [sum_bits(REF_SAMPLES, SAMPLE_BITS)-1:0]   sad_value,
    input  wire                                             sad_valid,
    output logic                                            capture_en,
    output logic                                            trigger,
    output logic                                            triggered
);

    // windows from an earlier run drain out within this many edges of a new run
    localparam logic [1:0] RUN_SETTLED = 2'd3;

    logic [1:0] state;
    logic [1:0] run_age;
    logic       match;
    logic       fire;

    assign capture_en = (state == ST_RUNNING);

    assign match = sad_valid && (THRESHOLD_BITS'(sad_value) <= threshold);

    // a window still in flight from the previous run must not fire
    assign fire = capture_en && active && match && (run_age == RUN_SETTLED);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state   <= ST_IDLE;
            run_age <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    run_age <= '0;
                    if (armed_and_ready && active) begin
                        state <= ST_RUNNING;
                    end
                end
                ST_RUNNING: begin
                    if (run_age != RUN_SETTLED) begin
                        run_age <= run_age + 1'b1;
                    end
                    if (!active) begin
                        state <= ST_DONE;
                    end else if (fire && !multiple_triggers) begin
                        state <= ST_DONE;  // single shot, wait for disarm
                    end
                end
                ST_DONE: begin
                    run_age <= '0;
                    if (!armed_and_ready || clear_status) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger   <= 1'b0;
            triggered <= 1'b0;
        end else begin
            trigger <= fire;  // one pulse per matching window
            if (clear_status) begin
                triggered <= 1'b0;
            end else if (fire) begin
                triggered <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sad_trigger_top.sv
`default_nettype none

module sad_trigger_top
    import sad_pkg::*;
#(
    parameter int REF_SAMPLES = 32,
    parameter int SAMPLE_BITS = 8
) (
    input  wire                                 adc_sampleclk,
    input  wire                                 reset,
    input  wire  [SAMPLE_BITS-1:0]              adc_datain,
    input  wire                                 armed_and_ready,
    input  wire                                 active,
    input  wire                                 ref_wr,
    input  wire  [index_bits(REF_SAMPLES)-1:0]  ref_index,
    input  wire  [SAMPLE_BITS-1:0]              ref_data,
    input  wire  [THRESHOLD_BITS-1:0]           threshold,
    input  wire                                 multiple_triggers,
    input  wire                                 clear_status,
    output logic                                trigger,
    output logic                                triggered
);

    localparam int SAD_BITS = sum_bits(REF_SAMPLES, SAMPLE_BITS);

    logic                               capture_en;
    logic [REF_SAMPLES*SAMPLE_BITS-1:0] window_samples;
    logic                               window_valid;
    logic [REF_SAMPLES*SAMPLE_BITS-1:0] ref_samples;
    logic [REF_SAMPLES*SAMPLE_BITS-1:0] diffs;
    logic                               diff_valid;
    logic [SAD_BITS-1:0]                sad_value;
    logic                               sad_valid;

    sad_reference_store #(
        .REF_SAMPLES (REF_SAMPLES),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) u_reference_store (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .ref_wr        (ref_wr),
        .ref_index     (ref_index),
        .ref_data      (ref_data),
        .ref_samples   (ref_samples)
    );

    sad_sample_window #(
        .REF_SAMPLES (REF_SAMPLES),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) u_sample_window (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .capture_en     (capture_en),
        .adc_datain     (adc_datain),
        .window_samples (window_samples),
        .window_valid   (window_valid)
    );

    sad_abs_diff #(
        .REF_SAMPLES (REF_SAMPLES),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) u_abs_diff (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .window_samples (window_samples),
        .window_valid   (window_valid),
        .ref_samples    (ref_samples),
        .diffs          (diffs),
        .diff_valid     (diff_valid)
    );

    sad_sum_tree #(
        .REF_SAMPLES (REF_SAMPLES),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) u_sum_tree (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .diffs         (diffs),
        .diff_valid    (diff_valid),
        .sad_value     (sad_value),
        .sad_valid     (sad_valid)
    );

    sad_trigger_control #(
        .REF_SAMPLES (REF_SAMPLES),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) u_trigger_control (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .sad_value         (sad_value),
        .sad_valid         (sad_valid),
        .capture_en        (capture_en),
        .trigger           (trigger),
        .triggered         (triggered)
    );

endmodule

`default_nettype wire

//--- dv/sad_tb.sv
`default_nettype none

module sad_tb
    import sad_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REF_SAMPLES = 8;
    localparam int SAMPLE_BITS = 8;
    localparam int IDX_BITS    = index_bits(REF_SAMPLES);

    logic                   adc_sampleclk;
    logic                   reset;
    logic [SAMPLE_BITS-1:0] adc_datain;
    logic                   armed_and_ready;
    logic                   active;
    logic                   ref_wr;
    logic [IDX_BITS-1:0]    ref_index;
    logic [SAMPLE_BITS-1:0] ref_data;
    logic [31:0]            threshold;
    logic                   multiple_triggers;
    logic                   clear_status;
    logic                   trigger;
    logic                   triggered;

    string                  test_name = "reset";
    logic [SAMPLE_BITS-1:0] ref_pat [REF_SAMPLES];    // pattern last written to the DUT

    // model state
    logic                   model_ready = 1'b0;
    logic [1:0]             model_state;
    logic [SAMPLE_BITS-1:0] model_ref [REF_SAMPLES];
    logic [SAMPLE_BITS-1:0] hist [$];                 // samples of the current run with oldest first
    logic                   pipe_v [4];
    logic [31:0]            pipe_sad [4];
    logic                   exp_trigger;
    logic                   exp_triggered;

    sad_trigger_top #(
        .REF_SAMPLES (REF_SAMPLES),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) u_sad_trigger_top (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .adc_datain        (adc_datain),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .ref_wr            (ref_wr),
        .ref_index         (ref_index),
        .ref_data          (ref_data),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .trigger           (trigger),
        .triggered         (triggered)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #10 adc_sampleclk = ~adc_sampleclk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        report_failure($sformatf("MISMATCH %s %s expected %0d actual %0d",
                                 test_name, what, exp, act));
    endtask

    // slot 0 of the reference pairs with the oldest sample
    function automatic logic [31:0] window_sad();
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < REF_SAMPLES; i++) begin
            if (hist[i] > model_ref[i]) begin
                sum += 32'(hist[i] - model_ref[i]);
            end else begin
                sum += 32'(model_ref[i] - hist[i]);
            end
        end
        return sum;
    endfunction

    // model of the run rules evaluated on pre-edge values
    always @(posedge adc_sampleclk) begin
        logic       fire;
        logic [1:0] prev_state;
        if (model_ready) begin
            assert (trigger === exp_trigger)
                else report_mismatch("trigger", exp_trigger, trigger);
            assert (triggered === exp_triggered)
                else report_mismatch("triggered", exp_triggered, triggered);
        end
        if (reset) begin
            model_ready   = 1'b1;
            model_state   = ST_IDLE;
            exp_trigger   = 1'b0;
            exp_triggered = 1'b0;
            hist.delete();
            for (int i = 0; i < 4; i++) pipe_v[i] = 1'b0;
            for (int i = 0; i < REF_SAMPLES; i++) model_ref[i] = '0;
        end else begin
            if (ref_wr) model_ref[ref_index] = ref_data;
            fire = (model_state == ST_RUNNING) && active && pipe_v[3]
                && (pipe_sad[3] <= threshold);
            prev_state = model_state;
            case (model_state)
                ST_IDLE: begin
                    if (armed_and_ready && active) begin
                        model_state = ST_RUNNING;
                        for (int i = 0; i < 4; i++) pipe_v[i] = 1'b0;  // fresh run
                    end
                end
                ST_RUNNING: begin
                    if (!active || (fire && !multiple_triggers)) model_state = ST_DONE;
                end
                default: begin
                    if (!armed_and_ready || clear_status) model_state = ST_IDLE;
                end
            endcase
            for (int i = 3; i > 0; i--) begin
                pipe_v[i]   = pipe_v[i-1];
                pipe_sad[i] = pipe_sad[i-1];
            end
            pipe_v[0] = 1'b0;
            if (prev_state == ST_RUNNING) begin
                hist.push_back(adc_datain);
                if (hist.size() > REF_SAMPLES) void'(hist.pop_front());
                if (hist.size() == REF_SAMPLES) begin
                    pipe_v[0]   = 1'b1;
                    pipe_sad[0] = window_sad();
                end
            end else begin
                hist.delete();
            end
            exp_trigger = fire;
            if (clear_status) exp_triggered = 1'b0;
            else if (fire) exp_triggered = 1'b1;
        end
    end

    reset_clears_outputs: assert property (@(posedge adc_sampleclk)
        reset |=> (!trigger && !triggered))
        else report_failure("trigger or triggered was high after a reset cycle");

    single_pulse_width: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (trigger && !multiple_triggers) |=> !trigger)
        else report_failure("trigger stayed high for a second cycle in single-trigger mode");

    task automatic drive_sample(input logic [SAMPLE_BITS-1:0] value);
        @(posedge adc_sampleclk);
        adc_datain <= value;
    endtask

    task automatic expect_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            drive_sample(SAMPLE_BITS'($urandom_range(255)));
            assert (trigger === 1'b0) else report_mismatch("quiet trigger", 0, trigger);
        end
    endtask

    task automatic send_pattern();
        for (int i = 0; i < REF_SAMPLES; i++) drive_sample(ref_pat[i]);
    endtask

    task automatic write_new_reference();
        for (int i = 0; i < REF_SAMPLES; i++) begin
            ref_pat[i] = SAMPLE_BITS'($urandom_range(255));
            @(posedge adc_sampleclk);
            ref_wr    <= 1'b1;
            ref_index <= IDX_BITS'(i);
            ref_data  <= ref_pat[i];
        end
        @(posedge adc_sampleclk);
        ref_wr <= 1'b0;
    endtask

    task automatic start_run(input logic multi, input logic [31:0] thr);
        @(posedge adc_sampleclk);
        multiple_triggers <= multi;
        threshold         <= thr;
        armed_and_ready   <= 1'b1;
        active            <= 1'b1;
    endtask

    task automatic stop_run();
        @(posedge adc_sampleclk);
        active          <= 1'b0;
        armed_and_ready <= 1'b0;
        repeat (6) @(posedge adc_sampleclk);
    endtask

    task automatic wait_for_trigger(input string what, input int limit, output int cycles);
        cycles = 0;
        do begin
            @(posedge adc_sampleclk);
            cycles++;
            if (cycles > limit) begin
                report_failure($sformatf("timeout after %0d cycles waiting for %s", limit, what));
            end
        end while (trigger !== 1'b1);
    endtask

    initial begin
        int          cycles;
        logic [31:0] thr;
        void'($urandom(32'h6902));
        reset             = 1'b1;
        adc_datain        = '0;
        armed_and_ready   = 1'b0;
        active            = 1'b0;
        ref_wr            = 1'b0;
        ref_index         = '0;
        ref_data          = '0;
        threshold         = '0;
        multiple_triggers = 1'b0;
        clear_status      = 1'b0;
        repeat (4) @(posedge adc_sampleclk);
        reset <= 1'b0;

        // nothing fires while unarmed even at the loosest threshold
        @(posedge adc_sampleclk);
        threshold         <= '1;
        active            <= 1'b1;
        multiple_triggers <= 1'b1;
        expect_quiet(20);
        assert (triggered === 1'b0) else report_mismatch("triggered", 0, triggered);
        active <= 1'b0;

        test_name = "window_fill";
        write_new_reference();
        start_run(1'b1, '1);
        wait_for_trigger("first trigger of a filling window", 40, cycles);
        // arm edge plus REF_SAMPLES captures plus 4 pipeline edges plus one edge to observe
        assert (cycles == REF_SAMPLES + 6)
            else report_mismatch("cycles to first trigger", REF_SAMPLES + 6, cycles);
        for (int i = 0; i < 10; i++) begin
            drive_sample(SAMPLE_BITS'($urandom_range(255)));
            assert (trigger === 1'b1) else report_mismatch("steady trigger", 1, trigger);
        end
        stop_run();

        test_name = "multi_random";
        write_new_reference();
        thr = 400 + $urandom_range(500);
        start_run(1'b1, thr);
        repeat (200) drive_sample(SAMPLE_BITS'($urandom_range(255)));
        stop_run();

        test_name = "single_shot";
        start_run(1'b0, 32'd0);
        expect_quiet(20);
        send_pattern();
        wait_for_trigger("single shot trigger", 20, cycles);
        assert (cycles == 6) else report_mismatch("pattern to trigger cycles", 6, cycles);
        drive_sample(SAMPLE_BITS'($urandom_range(255)));
        assert (triggered === 1'b1) else report_mismatch("triggered", 1, triggered);
        expect_quiet(20);
        send_pattern();     // still armed but must stay silent
        expect_quiet(10);
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b0;
        repeat (2) @(posedge adc_sampleclk);
        armed_and_ready <= 1'b1;
        expect_quiet(10);
        send_pattern();
        wait_for_trigger("trigger after rearm", 20, cycles);
        assert (cycles == 6) else report_mismatch("rearm trigger cycles", 6, cycles);
        stop_run();

        test_name = "active_exit";
        start_run(1'b1, '1);
        wait_for_trigger("trigger before active drops", 40, cycles);
        @(posedge adc_sampleclk);
        active <= 1'b0;
        repeat (4) drive_sample(SAMPLE_BITS'($urandom_range(255)));
        expect_quiet(10);
        assert (triggered === 1'b1) else report_mismatch("triggered", 1, triggered);
        @(posedge adc_sampleclk);
        clear_status <= 1'b1;
        @(posedge adc_sampleclk);
        clear_status <= 1'b0;
        @(posedge adc_sampleclk);
        assert (triggered === 1'b0) else report_mismatch("cleared triggered", 0, triggered);
        armed_and_ready <= 1'b0;

        // zero threshold only fires on the newly written pattern
        test_name = "ref_rewrite";
        write_new_reference();
        start_run(1'b1, 32'd0);
        expect_quiet(10);
        send_pattern();
        wait_for_trigger("trigger on rewritten reference", 20, cycles);
        assert (cycles == 6) else report_mismatch("rewrite trigger cycles", 6, cycles);
        threshold <= 400 + $urandom_range(500);
        repeat (100) drive_sample(SAMPLE_BITS'($urandom_range(255)));
        stop_run();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/sad_pkg.sv
design/sad_reference_store.sv
design/sad_sample_window.sv
design/sad_abs_diff.sv
design/sad_sum_tree.sv
design/sad_trigger_control.sv
design/sad_trigger_top.sv
dv/sad_tb.sv
